/* logic/hdr_cfg.svh */
/*
  HDR path configuration
  widths, mode code and special register-file addresses shared by the HDR blocks
*/
`ifndef HDR_CFG_SVH
`define HDR_CFG_SVH

`define HDR_ADDR_W      12         // register-file address bus
`define HDR_DATA_W      16         // payload word
`define HDR_IDX_W       5          // base and len fields of a command
`define HDR_REGF_DEPTH  32         // stored words

`define HDR_MODE_DDR    3'd6       // mode code for HDR-DDR

`define HDR_DUMMY_ADDR  12'd450    // decodes to the dummy word
`define HDR_IDLE_ADDR   12'd1000   // parked address when nobody reads
`define HDR_DUMMY_WORD  16'hA5C3   // filler sent between CCC and DDR

`endif

/* logic/hdr_pkg.sv */
/*
  HDR path package
  command and frame types, path select and the HDR-DDR parity function
*/
`default_nettype none

`include "hdr_cfg.svh"

package hdr_pkg;

  typedef struct packed {
    logic                  cp;    // 1 = CCC, 0 = plain DDR transfer
    logic                  toc;   // 1 = exit, 0 = restart
    logic [2:0]            mode;
    logic [`HDR_IDX_W-1:0] base;  // first word in the regfile
    logic [`HDR_IDX_W-1:0] len;   // words, 1 to 16
  } hdr_cmd_t;

  typedef struct packed {
    logic [1:0]             par;
    logic [`HDR_DATA_W-1:0] data;
  } hdr_frame_t;

  typedef enum logic {
    PATH_DDR = 1'b0,
    PATH_CCC = 1'b1
  } hdr_path_e;

  // upper bit covers the odd data bits, lower bit the even ones, inverted
  function automatic logic [1:0] hdr_parity(input logic [`HDR_DATA_W-1:0] data);
    logic odd_p;
    logic even_p;
    odd_p  = 1'b0;
    even_p = 1'b0;
    for (int i = 0; i < `HDR_DATA_W; i += 2) begin
      even_p ^= data[i];
      odd_p  ^= data[i+1];
    end
    return {odd_p, ~even_p};
  endfunction

endpackage

`default_nettype wire

/* logic/hdr_regf.sv */
/*
  HDR register file
  command and payload words, host write port, synchronous read with a dummy address
*/
`default_nettype none

`include "hdr_cfg.svh"

module hdr_regf (
  input  wire logic                   i_sys_clk,
  input  wire logic                   i_sys_rst_n,
  input  wire logic                   i_wr_en,
  input  wire logic [`HDR_ADDR_W-1:0] i_wr_addr,
  input  wire logic [`HDR_DATA_W-1:0] i_wr_data,
  input  wire logic                   i_rd_en,
  input  wire logic [`HDR_ADDR_W-1:0] i_rd_addr,
  output logic      [`HDR_DATA_W-1:0] o_rd_data
);

  localparam int IDX_W = $clog2(`HDR_REGF_DEPTH);

  logic [`HDR_DATA_W-1:0] mem [`HDR_REGF_DEPTH];
  logic                   wr_hit;

  assign wr_hit = i_wr_en && (i_wr_addr < `HDR_REGF_DEPTH);

  always_ff @(posedge i_sys_clk or negedge i_sys_rst_n) begin
    if (!i_sys_rst_n) begin
      for (int i = 0; i < `HDR_REGF_DEPTH; i++) begin
        mem[i] <= '0;
      end
      o_rd_data <= '0;
    end else begin
      if (wr_hit) begin
        mem[i_wr_addr[IDX_W-1:0]] <= i_wr_data;
      end
      if (i_rd_en) begin
        if (i_rd_addr == `HDR_DUMMY_ADDR) begin
          o_rd_data <= `HDR_DUMMY_WORD;
        end else if (i_rd_addr < `HDR_REGF_DEPTH) begin
          o_rd_data <= mem[i_rd_addr[IDX_W-1:0]];
        end else begin
          o_rd_data <= '0;   // unmapped
        end
      end
    end
  end

endmodule

`default_nettype wire

/* logic/hdr_engine.sv */
/*
  HDR engine
  chooses CCC or DDR sequencing per command, steers the transmit path
  and chains restarts until a command asks for an exit
*/
`default_nettype none

`include "hdr_cfg.svh"

module hdr_engine (
  input  wire logic               i_sys_clk,
  input  wire logic               i_sys_rst_n,
  input  wire logic               i_hdr_en,
  input  wire hdr_pkg::hdr_cmd_t  i_cmd,
  input  wire logic               i_ccc_done,
  input  wire logic               i_ddr_done,
  output logic                    o_ccc_start,
  output logic                    o_ccc_dummy,
  output logic                    o_ddr_start,
  output hdr_pkg::hdr_cmd_t       o_cmd,
  output hdr_pkg::hdr_path_e      o_path,
  output logic                    o_busy,
  output logic                    o_hdr_done
);

  import hdr_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE = 2'b00,
    ST_CCC  = 2'b01,
    ST_DDR  = 2'b10
  } state_e;

  state_e state;
  logic   dummy_pend;   // dummy CCC word in flight, DDR follows
  logic   exit_now;

  // exit on toc, or on any mode that is not HDR-DDR
  assign exit_now = o_cmd.toc || (o_cmd.mode != `HDR_MODE_DDR);
  assign o_busy   = (state != ST_IDLE);

  always_ff @(posedge i_sys_clk or negedge i_sys_rst_n) begin
    if (!i_sys_rst_n) begin
      state       <= ST_IDLE;
      o_cmd       <= '0;
      o_path      <= PATH_DDR;
      o_ccc_start <= 1'b0;
      o_ccc_dummy <= 1'b0;
      o_ddr_start <= 1'b0;
      o_hdr_done  <= 1'b0;
      dummy_pend  <= 1'b0;
    end else begin
      o_ccc_start <= 1'b0;   // pulses
      o_ddr_start <= 1'b0;
      o_hdr_done  <= 1'b0;
      case (state)
        ST_IDLE: begin
          o_ccc_dummy <= 1'b0;
          dummy_pend  <= 1'b0;
          if (i_hdr_en) begin
            o_cmd <= i_cmd;
            if (i_cmd.cp) begin
              o_ccc_start <= 1'b1;
              o_path      <= PATH_CCC;
              state       <= ST_CCC;
            end else begin
              o_ddr_start <= 1'b1;
              o_path      <= PATH_DDR;
              state       <= ST_DDR;
            end
          end
        end

        ST_CCC: begin
          if (!i_hdr_en) begin
            state <= ST_IDLE;     // abort, no done
          end else if (i_ccc_done) begin
            if (dummy_pend) begin
              // dummy word sent, now run the latched DDR command
              dummy_pend  <= 1'b0;
              o_ccc_dummy <= 1'b0;
              o_ddr_start <= 1'b1;
              o_path      <= PATH_DDR;
              state       <= ST_DDR;
            end else if (exit_now) begin
              o_hdr_done <= 1'b1;
              state      <= ST_IDLE;
            end else begin
              o_cmd       <= i_cmd;
              o_ccc_start <= 1'b1;
              if (!i_cmd.cp) begin
                o_ccc_dummy <= 1'b1;   // one filler word first
                dummy_pend  <= 1'b1;
              end
            end
          end
        end

        ST_DDR: begin
          if (!i_hdr_en) begin
            state <= ST_IDLE;
          end else if (i_ddr_done) begin
            if (exit_now) begin
              o_hdr_done <= 1'b1;
              state      <= ST_IDLE;
            end else begin
              o_cmd <= i_cmd;
              if (i_cmd.cp) begin
                o_ccc_start <= 1'b1;
                o_path      <= PATH_CCC;
                state       <= ST_CCC;
              end else begin
                o_ddr_start <= 1'b1;   // stay on DDR
              end
            end
          end
        end

        default: state <= ST_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

/* logic/ccc_sequencer.sv */
/*
  CCC sequencer
  reads a CCC word sequence, or one dummy word, and frames it with HDR-DDR parity
*/
`default_nettype none

`include "hdr_cfg.svh"

module ccc_sequencer (
  input  wire logic                   i_sys_clk,
  input  wire logic                   i_sys_rst_n,
  input  wire logic                   i_start,
  input  wire logic                   i_dummy,
  input  wire hdr_pkg::hdr_cmd_t      i_cmd,
  input  wire logic [`HDR_DATA_W-1:0] i_rd_data,
  output logic                        o_rd_en,
  output logic      [`HDR_ADDR_W-1:0] o_rd_addr,
  output logic                        o_frame_valid,
  output hdr_pkg::hdr_frame_t         o_frame,
  output logic                        o_done
);

  import hdr_pkg::*;

  localparam int ADDR_W = `HDR_ADDR_W;

  logic [`HDR_IDX_W-1:0] rd_left;   // reads still to issue after this one
  logic                  last_vld;  // returning word is the final one

  always_ff @(posedge i_sys_clk or negedge i_sys_rst_n) begin
    if (!i_sys_rst_n) begin
      o_rd_en       <= 1'b0;
      o_rd_addr     <= '0;
      rd_left       <= '0;
      o_frame_valid <= 1'b0;
      last_vld      <= 1'b0;
      o_done        <= 1'b0;
    end else begin
      o_frame_valid <= o_rd_en;              // data comes back a cycle later
      last_vld      <= o_rd_en && (rd_left == '0);
      o_done        <= last_vld;
      if (i_start) begin
        o_rd_en <= 1'b1;
        if (i_dummy) begin
          o_rd_addr <= `HDR_DUMMY_ADDR;
          rd_left   <= '0;                     // single word
        end else begin
          o_rd_addr <= ADDR_W'(i_cmd.base);
          rd_left   <= i_cmd.len - 1'b1;
        end
      end else if (o_rd_en) begin
        if (rd_left == '0) begin
          o_rd_en <= 1'b0;
        end else begin
          o_rd_addr <= o_rd_addr + 1'b1;
          rd_left   <= rd_left - 1'b1;
        end
      end
    end
  end

  always_comb begin
    o_frame.data = i_rd_data;
    o_frame.par  = hdr_parity(i_rd_data);
  end

endmodule

`default_nettype wire

/* logic/ddr_sequencer.sv */
/*
  DDR sequencer
  walks the payload words of an HDR-DDR transfer and frames them with parity
*/
`default_nettype none

`include "hdr_cfg.svh"

module ddr_sequencer (
  input  wire logic                   i_sys_clk,
  input  wire logic                   i_sys_rst_n,
  input  wire logic                   i_start,
  input  wire hdr_pkg::hdr_cmd_t      i_cmd,
  input  wire logic [`HDR_DATA_W-1:0] i_rd_data,
  output logic                        o_rd_en,
  output logic      [`HDR_ADDR_W-1:0] o_rd_addr,
  output logic                        o_frame_valid,
  output hdr_pkg::hdr_frame_t         o_frame,
  output logic                        o_done
);

  import hdr_pkg::*;

  localparam int ADDR_W = `HDR_ADDR_W;

  logic [`HDR_IDX_W-1:0] base_q;
  logic [`HDR_IDX_W-1:0] len_q;
  logic [`HDR_IDX_W-1:0] word_idx;   // payload word being read
  logic                  last_rd;
  logic                  last_vld;

  assign last_rd   = (word_idx == len_q - 1'b1);
  assign o_rd_addr = ADDR_W'(base_q) + ADDR_W'(word_idx);

  always_ff @(posedge i_sys_clk or negedge i_sys_rst_n) begin
    if (!i_sys_rst_n) begin
      base_q        <= '0;
      len_q         <= '0;
      word_idx      <= '0;
      o_rd_en       <= 1'b0;
      o_frame_valid <= 1'b0;
      last_vld      <= 1'b0;
      o_done        <= 1'b0;
    end else begin
      o_frame_valid <= o_rd_en;
      last_vld      <= o_rd_en && last_rd;
      o_done        <= last_vld;   // one cycle after last data
      if (i_start) begin
        base_q   <= i_cmd.base;
        len_q    <= i_cmd.len;
        word_idx <= '0;
        o_rd_en  <= 1'b1;
      end else if (o_rd_en) begin
        if (last_rd) begin
          o_rd_en <= 1'b0;
        end else begin
          word_idx <= word_idx + 1'b1;
        end
      end
    end
  end

  always_comb begin
    o_frame.data = i_rd_data;
    o_frame.par  = hdr_parity(i_rd_data);
  end

endmodule

`default_nettype wire

/* logic/hdr_path_mux.sv */
/*
  HDR path multiplexer
  joins the CCC and DDR sequencers onto one read port and one registered tx port
*/
`default_nettype none

`include "hdr_cfg.svh"

module hdr_path_mux (
  input  wire logic                   i_sys_clk,
  input  wire logic                   i_sys_rst_n,
  input  wire hdr_pkg::hdr_path_e     i_path,
  input  wire logic                   i_ccc_rd_en,
  input  wire logic [`HDR_ADDR_W-1:0] i_ccc_rd_addr,
  input  wire logic                   i_ccc_frame_valid,
  input  wire hdr_pkg::hdr_frame_t    i_ccc_frame,
  input  wire logic                   i_ddr_rd_en,
  input  wire logic [`HDR_ADDR_W-1:0] i_ddr_rd_addr,
  input  wire logic                   i_ddr_frame_valid,
  input  wire hdr_pkg::hdr_frame_t    i_ddr_frame,
  output logic                        o_rd_en,
  output logic      [`HDR_ADDR_W-1:0] o_rd_addr,
  output logic                        o_tx_valid,
  output hdr_pkg::hdr_frame_t         o_tx_frame
);

  import hdr_pkg::*;

  logic sel_ccc;

  assign sel_ccc = (i_path == PATH_CCC);

  // read side, address parked when no read is strobed
  always_comb begin
    o_rd_en   = sel_ccc ? i_ccc_rd_en : i_ddr_rd_en;
    o_rd_addr = `HDR_IDLE_ADDR;
    if (o_rd_en) begin
      o_rd_addr = sel_ccc ? i_ccc_rd_addr : i_ddr_rd_addr;
    end
  end

  always_ff @(posedge i_sys_clk or negedge i_sys_rst_n) begin
    if (!i_sys_rst_n) begin
      o_tx_valid <= 1'b0;
    end else begin
      o_tx_valid <= sel_ccc ? i_ccc_frame_valid : i_ddr_frame_valid;
    end
  end

  always_ff @(posedge i_sys_clk) begin
    o_tx_frame <= sel_ccc ? i_ccc_frame : i_ddr_frame;
  end

endmodule

`default_nettype wire

/* logic/hdr_subsys.sv */
/*
  HDR subsystem top
  engine, CCC and DDR sequencers, path mux and register file
*/
`default_nettype none

`include "hdr_cfg.svh"

module hdr_subsys (
  input  wire logic                   i_sys_clk,
  input  wire logic                   i_sys_rst_n,
  input  wire logic                   i_wr_en,
  input  wire logic [`HDR_ADDR_W-1:0] i_wr_addr,
  input  wire logic [`HDR_DATA_W-1:0] i_wr_data,
  input  wire hdr_pkg::hdr_cmd_t      i_cmd,
  input  wire logic                   i_hdr_en,
  output logic                        o_tx_valid,
  output hdr_pkg::hdr_frame_t         o_tx_frame,
  output logic                        o_hdr_done,
  output logic                        o_busy,
  output hdr_pkg::hdr_path_e          o_path
);

  import hdr_pkg::*;

  hdr_cmd_t               seq_cmd;
  logic                   ccc_start;
  logic                   ccc_dummy;
  logic                   ccc_done;
  logic                   ddr_start;
  logic                   ddr_done;
  logic                   ccc_rd_en;
  logic [`HDR_ADDR_W-1:0] ccc_rd_addr;
  logic                   ccc_frame_valid;
  hdr_frame_t             ccc_frame;
  logic                   ddr_rd_en;
  logic [`HDR_ADDR_W-1:0] ddr_rd_addr;
  logic                   ddr_frame_valid;
  hdr_frame_t             ddr_frame;
  logic                   rd_en;
  logic [`HDR_ADDR_W-1:0] rd_addr;
  logic [`HDR_DATA_W-1:0] rd_data;   // shared by both sequencers

  hdr_engine u_engine (
    .i_sys_clk   (i_sys_clk),
    .i_sys_rst_n (i_sys_rst_n),
    .i_hdr_en    (i_hdr_en),
    .i_cmd       (i_cmd),
    .i_ccc_done  (ccc_done),
    .i_ddr_done  (ddr_done),
    .o_ccc_start (ccc_start),
    .o_ccc_dummy (ccc_dummy),
    .o_ddr_start (ddr_start),
    .o_cmd       (seq_cmd),
    .o_path      (o_path),
    .o_busy      (o_busy),
    .o_hdr_done  (o_hdr_done)
  );

  ccc_sequencer u_ccc_seq (
    .i_sys_clk     (i_sys_clk),
    .i_sys_rst_n   (i_sys_rst_n),
    .i_start       (ccc_start),
    .i_dummy       (ccc_dummy),
    .i_cmd         (seq_cmd),
    .i_rd_data     (rd_data),
    .o_rd_en       (ccc_rd_en),
    .o_rd_addr     (ccc_rd_addr),
    .o_frame_valid (ccc_frame_valid),
    .o_frame       (ccc_frame),
    .o_done        (ccc_done)
  );

  ddr_sequencer u_ddr_seq (
    .i_sys_clk     (i_sys_clk),
    .i_sys_rst_n   (i_sys_rst_n),
    .i_start       (ddr_start),
    .i_cmd         (seq_cmd),
    .i_rd_data     (rd_data),
    .o_rd_en       (ddr_rd_en),
    .o_rd_addr     (ddr_rd_addr),
    .o_frame_valid (ddr_frame_valid),
    .o_frame       (ddr_frame),
    .o_done        (ddr_done)
  );

  hdr_path_mux u_path_mux (
    .i_sys_clk         (i_sys_clk),
    .i_sys_rst_n       (i_sys_rst_n),
    .i_path            (o_path),
    .i_ccc_rd_en       (ccc_rd_en),
    .i_ccc_rd_addr     (ccc_rd_addr),
    .i_ccc_frame_valid (ccc_frame_valid),
    .i_ccc_frame       (ccc_frame),
    .i_ddr_rd_en       (ddr_rd_en),
    .i_ddr_rd_addr     (ddr_rd_addr),
    .i_ddr_frame_valid (ddr_frame_valid),
    .i_ddr_frame       (ddr_frame),
    .o_rd_en           (rd_en),
    .o_rd_addr         (rd_addr),
    .o_tx_valid        (o_tx_valid),
    .o_tx_frame        (o_tx_frame)
  );

  hdr_regf u_regf (
    .i_sys_clk   (i_sys_clk),
    .i_sys_rst_n (i_sys_rst_n),
    .i_wr_en     (i_wr_en),
    .i_wr_addr   (i_wr_addr),
    .i_wr_data   (i_wr_data),
    .i_rd_en     (rd_en),
    .i_rd_addr   (rd_addr),
    .o_rd_data   (rd_data)
  );

endmodule

`default_nettype wire

/* sim/tb_hdr_subsys.sv */
/*
  HDR subsystem testbench
  loads the register file, runs CCC and DDR command chains and compares every tx frame
  against a reference model built from the chaining rules
*/
`default_nettype none

`include "hdr_cfg.svh"

module tb_hdr_subsys;

  import hdr_pkg::*;

  localparam int WAIT_LIMIT = 500;   // cycles per wait loop

  logic                   i_sys_clk;
  logic                   i_sys_rst_n;
  logic                   i_wr_en;
  logic [`HDR_ADDR_W-1:0] i_wr_addr;
  logic [`HDR_DATA_W-1:0] i_wr_data;
  hdr_cmd_t               i_cmd;
  logic                   i_hdr_en;
  logic                   o_tx_valid;
  hdr_frame_t             o_tx_frame;
  logic                   o_hdr_done;
  logic                   o_busy;
  hdr_path_e              o_path;

  logic [`HDR_DATA_W-1:0] mem_ref [`HDR_REGF_DEPTH];   // host copy of the regfile
  hdr_cmd_t               chain[$];
  hdr_frame_t             exp_frames[$];               // cumulative over all runs
  hdr_path_e              exp_paths[$];
  int                     first_idx[$];                // first frame of each command
  int                     rx_count;
  int                     done_count;
  int                     checks;
  int                     errors;
  bit                     timed_out;
  integer                 seed;

  hdr_subsys DUT (
    .i_sys_clk   (i_sys_clk),
    .i_sys_rst_n (i_sys_rst_n),
    .i_wr_en     (i_wr_en),
    .i_wr_addr   (i_wr_addr),
    .i_wr_data   (i_wr_data),
    .i_cmd       (i_cmd),
    .i_hdr_en    (i_hdr_en),
    .o_tx_valid  (o_tx_valid),
    .o_tx_frame  (o_tx_frame),
    .o_hdr_done  (o_hdr_done),
    .o_busy      (o_busy),
    .o_path      (o_path)
  );

  always #4 i_sys_clk = ~i_sys_clk;

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED %s: got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  // HDR-DDR parity with the odd bits on top and the inverted even bits below
  function automatic hdr_frame_t ref_frame(input logic [`HDR_DATA_W-1:0] data);
    hdr_frame_t f;
    f.data   = data;
    f.par[1] = ^(data & 16'hAAAA);
    f.par[0] = ~(^(data & 16'h5555));
    return f;
  endfunction

  // expected frames and paths of the queued chain up to the command that exits
  function automatic void build_expected();
    hdr_cmd_t c;
    logic     prev_ccc;
    int       addr;
    first_idx.delete();
    prev_ccc = 1'b0;
    for (int k = 0; k < chain.size(); k++) begin
      c = chain[k];
      if (k > 0 && prev_ccc && !c.cp) begin   // CCC into DDR sends one filler first
        exp_frames.push_back(ref_frame(`HDR_DUMMY_WORD));
        exp_paths.push_back(PATH_CCC);
      end
      first_idx.push_back(exp_frames.size());
      for (int i = 0; i < c.len; i++) begin
        addr = c.base + i;
        if (addr < `HDR_REGF_DEPTH) begin
          exp_frames.push_back(ref_frame(mem_ref[addr]));
        end else begin
          exp_frames.push_back(ref_frame(16'h0000));
        end
        exp_paths.push_back(c.cp ? PATH_CCC : PATH_DDR);
      end
      prev_ccc = c.cp;
      if (c.toc || (c.mode != `HDR_MODE_DDR)) begin
        break;
      end
    end
  endfunction

  task automatic add_cmd(input logic cp, input logic toc, input logic [2:0] mode,
                         input int base, input int len);
    hdr_cmd_t c;
    c.cp   = cp;
    c.toc  = toc;
    c.mode = mode;
    c.base = base[`HDR_IDX_W-1:0];
    c.len  = len[`HDR_IDX_W-1:0];
    chain.push_back(c);
  endtask

  task automatic load_regf();
    integer rnd;
    for (int i = 0; i < `HDR_REGF_DEPTH; i++) begin
      rnd        = $random(seed);
      mem_ref[i] = rnd[`HDR_DATA_W-1:0];
      i_wr_en    = 1'b1;
      i_wr_addr  = i;
      i_wr_data  = rnd[`HDR_DATA_W-1:0];
      @(posedge i_sys_clk);
      #1;
    end
    i_wr_en = 1'b0;
  endtask

  // runs the queued chain and may drop the enable after the first frame
  task automatic run_chain(input bit abort);
    int done_base;
    int k;
    int cycles;
    if (timed_out) begin
      return;
    end
    done_base = done_count;
    build_expected();
    i_cmd    = chain[0];
    i_hdr_en = 1'b1;
    k        = 0;
    cycles   = 0;
    while (rx_count < exp_frames.size() && !timed_out) begin
      @(posedge i_sys_clk);
      #1;
      cycles++;
      if (i_hdr_en && rx_count < exp_frames.size()) begin
        compare_value("o_busy during transfer", o_busy, 1'b1);
      end
      if (k + 1 < chain.size() && k < first_idx.size()) begin
        if (rx_count > first_idx[k]) begin   // next command once this one is on air
          k++;
          i_cmd = chain[k];
        end
      end
      if (abort && i_hdr_en && rx_count > first_idx[0]) begin
        i_hdr_en = 1'b0;
      end
      if (cycles > WAIT_LIMIT) begin
        $display("timeout while waiting for the expected tx frames");
        errors++;
        timed_out = 1'b1;
      end
    end
    i_hdr_en = 1'b0;   // stops the engine from starting again after the last frame
    cycles   = 0;
    while (!abort && done_count == done_base && !timed_out) begin
      @(posedge i_sys_clk);
      #1;
      cycles++;
      if (cycles > WAIT_LIMIT) begin
        $display("timeout while waiting for the done pulse");
        errors++;
        timed_out = 1'b1;
      end
    end
    repeat (4) @(posedge i_sys_clk);   // quiet gap that catches extra frames or pulses
    #1;
    compare_value("o_hdr_done pulses", done_count - done_base, abort ? 0 : 1);
    compare_value("o_busy", o_busy, 1'b0);
    compare_value("tx frame count", rx_count, exp_frames.size());
    chain.delete();
  endtask

  // frame and done monitor on the falling edge
  always @(negedge i_sys_clk) begin
    if (i_sys_rst_n) begin
      if (o_hdr_done) begin
        done_count++;
      end
      if (o_tx_valid) begin
        if (rx_count < exp_frames.size()) begin
          compare_value("o_tx_frame", o_tx_frame, exp_frames[rx_count]);
          compare_value("o_path", o_path, exp_paths[rx_count]);
        end else begin
          $display("a tx frame arrived that the reference model does not expect");
          errors++;
        end
        rx_count++;
      end
    end
  end

  initial begin
    seed        = 32'h9af3748f;
    i_sys_clk   = 1'b0;
    i_sys_rst_n = 1'b0;
    i_wr_en     = 1'b0;
    i_wr_addr   = '0;
    i_wr_data   = '0;
    i_cmd       = '0;
    i_hdr_en    = 1'b0;
    rx_count    = 0;
    done_count  = 0;
    checks      = 0;
    errors      = 0;
    timed_out   = 1'b0;

    repeat (3) @(posedge i_sys_clk);
    #1;
    i_sys_rst_n = 1'b1;
    compare_value("o_busy after reset", o_busy, 1'b0);
    compare_value("o_tx_valid after reset", o_tx_valid, 1'b0);
    compare_value("o_hdr_done after reset", o_hdr_done, 1'b0);
    compare_value("o_path after reset", o_path, PATH_DDR);

    load_regf();

    add_cmd(1'b0, 1'b1, `HDR_MODE_DDR, 0, 8);    // single DDR
    run_chain(1'b0);
    add_cmd(1'b1, 1'b1, `HDR_MODE_DDR, 8, 4);    // single CCC
    run_chain(1'b0);
    add_cmd(1'b1, 1'b0, `HDR_MODE_DDR, 12, 3);   // CCC, dummy, DDR
    add_cmd(1'b0, 1'b1, `HDR_MODE_DDR, 16, 5);
    run_chain(1'b0);
    add_cmd(1'b0, 1'b0, `HDR_MODE_DDR, 2, 4);    // DDR, DDR, CCC
    add_cmd(1'b0, 1'b0, `HDR_MODE_DDR, 20, 6);
    add_cmd(1'b1, 1'b1, `HDR_MODE_DDR, 4, 2);
    run_chain(1'b0);
    add_cmd(1'b0, 1'b0, 3'd2, 6, 3);             // other mode exits despite toc=0
    add_cmd(1'b0, 1'b1, `HDR_MODE_DDR, 0, 2);
    run_chain(1'b0);
    add_cmd(1'b0, 1'b1, `HDR_MODE_DDR, 0, 10);   // issued reads still drain
    run_chain(1'b1);
    add_cmd(1'b1, 1'b1, `HDR_MODE_DDR, 10, 3);
    run_chain(1'b0);

    $display("summary: %0d checks, %0d errors, %0d frames, %0d done pulses",
             checks, errors, rx_count, done_count);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+logic
logic/hdr_pkg.sv
logic/hdr_regf.sv
logic/hdr_engine.sv
logic/ccc_sequencer.sv
logic/ddr_sequencer.sv
logic/hdr_path_mux.sv
logic/hdr_subsys.sv
sim/tb_hdr_subsys.sv

/* Bender.yml */
package:
  name: hdr_subsys

sources:
  - include_dirs:
      - logic
    files:
      - logic/hdr_pkg.sv
      - logic/hdr_regf.sv
      - logic/hdr_engine.sv
      - logic/ccc_sequencer.sv
      - logic/ddr_sequencer.sv
      - logic/hdr_path_mux.sv
      - logic/hdr_subsys.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - sim/tb_hdr_subsys.sv
